/* hdl/msg_pkg.sv */
// message checksum shared definitions
package msg_pkg;

	// number of independent checksum lanes
	localparam int NUM_LANES = 4;
	// bits needed to name one lane
	localparam int LANE_W = 2;
	// ascii code of digit zero that offsets each decimal digit
	localparam logic [7:0] ASCII_ZERO = 8'h30;

	// one message byte or a running sum
	typedef logic [7:0] byte_t;
	// lane index
	typedef logic [LANE_W-1:0] lane_t;
	// one output character
	typedef logic [7:0] ascii_t;

	// payload byte handed from the splitter to the lanes
	// last set with no strobe means the open frame was aborted
	typedef struct packed {
		byte_t data;
		logic  last;
	} lane_byte_s;

	// finished checksum as three ascii digits
	typedef struct packed {
		ascii_t hundreds;
		ascii_t tens;
		ascii_t ones;
	} result_s;

	// lane conversion FSM
	typedef enum logic [1:0] {
		CONV_IDLE,
		CONV_HUNDREDS,
		CONV_TENS,
		CONV_DONE
	} conv_state_e;

	// serializer FSM with one state per emitted digit
	typedef enum logic [1:0] {
		SER_IDLE,
		SER_SEND_H,
		SER_SEND_T,
		SER_SEND_O
	} ser_state_e;

endpackage

/* hdl/frame_splitter.sv */
// frame boundary tracker
`timescale 1ns/1ps

module frame_splitter (
	input  logic                          clk,
	input  logic                          rst,
	input  msg_pkg::byte_t                data_i,
	input  logic                          valid_i,
	input  logic                          start_i,
	input  logic                          end_i,
	output logic [msg_pkg::NUM_LANES-1:0] lane_strobe_o,
	output msg_pkg::lane_byte_s           lane_byte_o
);

	// frame currently open
	logic in_frame;
	// lane picked by the start byte
	msg_pkg::lane_t cur_lane;
	// accepted payload byte this cycle
	logic payload;
	// one-hot decode of cur_lane
	logic [msg_pkg::NUM_LANES-1:0] lane_hot;
	// registered payload fields
	msg_pkg::byte_t data_q;
	logic last_q;

	// start byte only selects a lane and is never summed
	assign payload = valid_i && !start_i && in_frame;

	always_comb begin
		lane_hot = '0;
		lane_hot[cur_lane] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			in_frame      <= 1'b0;
			cur_lane      <= '0;
			lane_strobe_o <= '0;
			last_q        <= 1'b0;
		end else begin
			// strobe and last are single-cycle pulses
			lane_strobe_o <= '0;
			last_q        <= 1'b0;
			if (valid_i && start_i) begin
				in_frame <= 1'b1;
				cur_lane <= data_i[msg_pkg::LANE_W-1:0];
				// a restart mid-frame sends last without strobe to drop the partial sum
				last_q   <= in_frame;
			end else if (payload) begin
				lane_strobe_o <= lane_hot;
				last_q        <= end_i;
				if (end_i) begin
					in_frame <= 1'b0;
				end
			end
		end
	end

	// payload data register
	always_ff @(posedge clk) begin
		if (payload) begin
			data_q <= data_i;
		end
	end

	assign lane_byte_o.data = data_q;
	assign lane_byte_o.last = last_q;

endmodule

/* hdl/checksum_lane.sv */
// checksum lane with decimal conversion
`timescale 1ns/1ps

module checksum_lane (
	input  logic                clk,
	input  logic                rst,
	input  logic                strobe_i,
	input  msg_pkg::lane_byte_s byte_i,
	input  logic                take_i,
	output logic                done_o,
	output msg_pkg::result_s    result_o
);

	msg_pkg::conv_state_e state;
	// running sum of the open frame
	msg_pkg::byte_t acc;
	// sum including the byte now arriving
	msg_pkg::byte_t final_sum;
	// frame completes this cycle
	logic frame_end;
	// remainder still to be split into digits
	msg_pkg::byte_t rem;
	// next remainder and tens count in TENS
	msg_pkg::byte_t rem_next;
	logic [3:0] tens_cnt;
	logic [3:0] tens_next;
	// hundreds digit already in ascii
	msg_pkg::ascii_t hund_q;
	msg_pkg::result_s result_q;

	assign final_sum = msg_pkg::byte_t'(acc + byte_i.data);
	assign frame_end = strobe_i && byte_i.last;

	// one subtraction of ten per cycle
	always_comb begin
		rem_next  = rem;
		tens_next = tens_cnt;
		if (rem >= 8'd10) begin
			rem_next  = msg_pkg::byte_t'(rem - 8'd10);
			tens_next = tens_cnt + 4'd1;
		end
	end

	// accumulator
	// last on the shared bus clears it with or without a strobe
	// only the lane of the open frame ever holds a partial sum
	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else if (byte_i.last) begin
			acc <= '0;
		end else if (strobe_i) begin
			acc <= msg_pkg::byte_t'(acc + byte_i.data);
		end
	end

	// conversion FSM
	// a new frame end restarts conversion from any state
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= msg_pkg::CONV_IDLE;
		end else if (frame_end) begin
			state <= msg_pkg::CONV_HUNDREDS;
		end else begin
			case (state)
				msg_pkg::CONV_HUNDREDS: begin
					state <= msg_pkg::CONV_TENS;
				end
				msg_pkg::CONV_TENS: begin
					// leave as soon as the remainder is a single digit
					if (rem_next < 8'd10) begin
						state <= msg_pkg::CONV_DONE;
					end
				end
				msg_pkg::CONV_DONE: begin
					// hold the result until the serializer takes it
					if (take_i) begin
						state <= msg_pkg::CONV_IDLE;
					end
				end
				default: begin
					state <= msg_pkg::CONV_IDLE;
				end
			endcase
		end
	end

	// digit datapath
	always_ff @(posedge clk) begin
		if (frame_end) begin
			rem <= final_sum;
		end else if (state == msg_pkg::CONV_HUNDREDS) begin
			tens_cnt <= '0;
			// two compares give the hundreds digit
			if (rem >= 8'd200) begin
				hund_q <= msg_pkg::ASCII_ZERO + 8'd2;
				rem    <= msg_pkg::byte_t'(rem - 8'd200);
			end else if (rem >= 8'd100) begin
				hund_q <= msg_pkg::ASCII_ZERO + 8'd1;
				rem    <= msg_pkg::byte_t'(rem - 8'd100);
			end else begin
				hund_q <= msg_pkg::ASCII_ZERO;
			end
		end else if (state == msg_pkg::CONV_TENS) begin
			rem      <= rem_next;
			tens_cnt <= tens_next;
			if (rem_next < 8'd10) begin
				result_q.hundreds <= hund_q;
				result_q.tens     <= msg_pkg::ASCII_ZERO + {4'd0, tens_next};
				// what is left over is the ones digit
				result_q.ones     <= msg_pkg::ASCII_ZERO + rem_next;
			end
		end
	end

	assign done_o   = (state == msg_pkg::CONV_DONE);
	assign result_o = result_q;

endmodule

/* hdl/digit_serializer.sv */
// round-robin digit serializer
`timescale 1ns/1ps

module digit_serializer (
	input  logic                                              clk,
	input  logic                                              rst,
	input  logic             [msg_pkg::NUM_LANES-1:0]         done_i,
	input  msg_pkg::result_s [msg_pkg::NUM_LANES-1:0]         result_i,
	output logic             [msg_pkg::NUM_LANES-1:0]         take_o,
	output msg_pkg::ascii_t                                   char_o,
	output logic                                              char_valid_o,
	output msg_pkg::lane_t                                    char_lane_o
);

	msg_pkg::ser_state_e state;
	// lane with the highest priority next time
	msg_pkg::lane_t ptr;
	// arbiter result
	msg_pkg::lane_t pick;
	msg_pkg::lane_t idx;
	logic found;
	logic [msg_pkg::NUM_LANES-1:0] pick_hot;
	// lane being served for the whole burst
	msg_pkg::lane_t sel_lane;
	// result captured in the take cycle
	msg_pkg::result_s res_q;

	// first finished lane at or after ptr with wraparound
	always_comb begin
		pick  = ptr;
		found = 1'b0;
		idx   = ptr;
		for (int i = 0; i < msg_pkg::NUM_LANES; i++) begin
			idx = msg_pkg::lane_t'((int'(ptr) + i) % msg_pkg::NUM_LANES);
			if (!found && done_i[idx]) begin
				pick  = idx;
				found = 1'b1;
			end
		end
		pick_hot       = '0;
		pick_hot[pick] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= msg_pkg::SER_IDLE;
			ptr          <= '0;
			sel_lane     <= '0;
			take_o       <= '0;
			char_valid_o <= 1'b0;
		end else begin
			take_o       <= '0;
			char_valid_o <= 1'b0;
			case (state)
				msg_pkg::SER_IDLE: begin
					if (|done_i) begin
						// take pulses in the next cycle
						take_o   <= pick_hot;
						sel_lane <= pick;
						ptr      <= msg_pkg::lane_t'((int'(pick) + 1) % msg_pkg::NUM_LANES);
						state    <= msg_pkg::SER_SEND_H;
					end
				end
				msg_pkg::SER_SEND_H: begin
					char_valid_o <= 1'b1;
					state        <= msg_pkg::SER_SEND_T;
				end
				msg_pkg::SER_SEND_T: begin
					char_valid_o <= 1'b1;
					state        <= msg_pkg::SER_SEND_O;
				end
				msg_pkg::SER_SEND_O: begin
					// going back to IDLE after the last digit leaves a gap before the next burst
					char_valid_o <= 1'b1;
					state        <= msg_pkg::SER_IDLE;
				end
				default: begin
					state <= msg_pkg::SER_IDLE;
				end
			endcase
		end
	end

	// character path
	always_ff @(posedge clk) begin
		case (state)
			msg_pkg::SER_SEND_H: begin
				// the lane still holds its result while take is high
				res_q  <= result_i[sel_lane];
				char_o <= result_i[sel_lane].hundreds;
			end
			msg_pkg::SER_SEND_T: begin
				char_o <= res_q.tens;
			end
			msg_pkg::SER_SEND_O: begin
				char_o <= res_q.ones;
			end
			default: begin
				char_o <= char_o;
			end
		endcase
	end

	assign char_lane_o = sel_lane;

endmodule

/* hdl/msg_checksum_top.sv */
// message checksum top level
`timescale 1ns/1ps

module msg_checksum_top (
	input  logic            clk,
	input  logic            rst,
	input  msg_pkg::byte_t  data_i,
	input  logic            valid_i,
	input  logic            start_i,
	input  logic            end_i,
	output msg_pkg::ascii_t char_o,
	output logic            char_valid_o,
	output msg_pkg::lane_t  char_lane_o
);

	// splitter to lanes
	logic [msg_pkg::NUM_LANES-1:0] lane_strobe;
	msg_pkg::lane_byte_s lane_byte;
	// lanes to serializer
	logic [msg_pkg::NUM_LANES-1:0] lane_done;
	msg_pkg::result_s [msg_pkg::NUM_LANES-1:0] lane_result;
	// serializer back to lanes
	logic [msg_pkg::NUM_LANES-1:0] lane_take;

	frame_splitter u_splitter (
		.clk           (clk),
		.rst           (rst),
		.data_i        (data_i),
		.valid_i       (valid_i),
		.start_i       (start_i),
		.end_i         (end_i),
		.lane_strobe_o (lane_strobe),
		.lane_byte_o   (lane_byte)
	);

	// one lane per strobe bit, all sharing the payload bus
	for (genvar g = 0; g < msg_pkg::NUM_LANES; g++) begin : g_lane
		checksum_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.strobe_i (lane_strobe[g]),
			.byte_i   (lane_byte),
			.take_i   (lane_take[g]),
			.done_o   (lane_done[g]),
			.result_o (lane_result[g])
		);
	end

	digit_serializer u_serializer (
		.clk          (clk),
		.rst          (rst),
		.done_i       (lane_done),
		.result_i     (lane_result),
		.take_o       (lane_take),
		.char_o       (char_o),
		.char_valid_o (char_valid_o),
		.char_lane_o  (char_lane_o)
	);

endmodule

/* tb/msg_checksum_sva.sv */
// output burst assertions
`timescale 1ns/1ps

module msg_checksum_sva (
	input logic           clk,
	input logic           rst,
	input logic           char_valid_i,
	input msg_pkg::lane_t char_lane_i
);

	// number of assertion failures so far
	int fail_count = 0;

	// every burst is three characters followed by a gap
	property burst_of_three;
		@(posedge clk) disable iff (rst)
		$rose(char_valid_i) |=> char_valid_i ##1 char_valid_i ##1 !char_valid_i;
	endproperty

	// lane tag does not move inside a burst
	property lane_steady;
		@(posedge clk) disable iff (rst)
		(char_valid_i && $past(char_valid_i)) |-> $stable(char_lane_i);
	endproperty

	// sync reset clears the strobe one edge later
	property quiet_in_reset;
		@(posedge clk)
		$past(rst) |-> !char_valid_i;
	endproperty

	a_burst_of_three: assert property (burst_of_three)
		else begin
			$error("char_valid_o burst is not three cycles long");
			fail_count++;
		end
	a_lane_steady: assert property (lane_steady)
		else begin
			$error("char_lane_o changed within a burst");
			fail_count++;
		end
	a_quiet_in_reset: assert property (quiet_in_reset)
		else begin
			$error("char_valid_o high during reset");
			fail_count++;
		end

endmodule

bind msg_checksum_top msg_checksum_sva u_sva (
	.clk          (clk),
	.rst          (rst),
	.char_valid_i (char_valid_o),
	.char_lane_i  (char_lane_o)
);

/* tb/msg_checksum_tb.sv */
// message checksum testbench
`timescale 1ns/1ps

module msg_checksum_tb;

	// upper bounds of bytes per test with nine bytes per random frame
	localparam int SENT_BYTES = 4 + 18 + 14 + 14 + 180;
	localparam int SENT_FRAMES = 1 + 7 + 4 + 4 + 20;
	localparam int CYCLE_LIMIT = 20 * SENT_BYTES + 40 * SENT_FRAMES;
	localparam int BURST_WAIT = 60;
	localparam logic [31:0] SEED = 32'hb41b6d59;

	// one captured output burst
	typedef struct packed {
		msg_pkg::lane_t   lane;
		msg_pkg::result_s chars;
	} burst_s;

	logic clk;
	logic rst;
	msg_pkg::byte_t data_i;
	logic valid_i;
	logic start_i;
	logic end_i;
	msg_pkg::ascii_t char_o;
	logic char_valid_o;
	msg_pkg::lane_t char_lane_o;

	burst_s bursts[$];
	burst_s cap;
	int beat;
	int errors;
	int checks;
	int cycles;
	logic [31:0] lfsr_state;

	msg_checksum_top DUT (
		.clk          (clk),
		.rst          (rst),
		.data_i       (data_i),
		.valid_i      (valid_i),
		.start_i      (start_i),
		.end_i        (end_i),
		.char_o       (char_o),
		.char_valid_o (char_valid_o),
		.char_lane_o  (char_lane_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// capture on negedge where the registered outputs are stable
	always @(negedge clk) begin
		if (rst || !char_valid_o) begin
			beat = 0;
		end else begin
			// hundreds ends up in the top field after three shifts
			cap.chars = {cap.chars[15:0], char_o};
			cap.lane = char_lane_o;
			beat = beat + 1;
			if (beat == 3) begin
				bursts.push_back(cap);
				beat = 0;
			end
		end
	end

	// x^32 + x^22 + x^2 + x + 1 with feedback shifted in at bit 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	task automatic rand_bits(input int n, output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	// reference sum modulo 256
	function automatic msg_pkg::byte_t payload_sum(input msg_pkg::byte_t p[$]);
		int acc;
		acc = 0;
		foreach (p[i]) begin
			acc += int'(p[i]);
		end
		return msg_pkg::byte_t'(acc % 256);
	endfunction

	// three ascii decimal digits with leading zeros
	function automatic msg_pkg::result_s expect_digits(input msg_pkg::byte_t s);
		msg_pkg::result_s r;
		r.hundreds = msg_pkg::ASCII_ZERO + msg_pkg::ascii_t'(s / 100);
		r.tens     = msg_pkg::ASCII_ZERO + msg_pkg::ascii_t'((s / 10) % 10);
		r.ones     = msg_pkg::ASCII_ZERO + msg_pkg::ascii_t'(s % 10);
		return r;
	endfunction

	task automatic check_char(input string name, input msg_pkg::ascii_t exp,
			input msg_pkg::ascii_t act);
		checks++;
		if (exp !== act) begin
			$display("mismatch %s: expected char %h '%c', actual %h '%c'",
				name, exp, exp, act, act);
			errors++;
		end
	endtask

	task automatic check_lane(input string name, input msg_pkg::lane_t exp,
			input msg_pkg::lane_t act);
		checks++;
		if (exp !== act) begin
			$display("mismatch %s: expected lane %0d, actual lane %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_result(input string name, input msg_pkg::result_s exp,
			input msg_pkg::result_s act);
		check_char(name, exp.hundreds, act.hundreds);
		check_char(name, exp.tens, act.tens);
		check_char(name, exp.ones, act.ones);
	endtask

	// drive one byte that stays on the bus until the next call or bus_idle
	task automatic send_byte(input msg_pkg::byte_t data, input logic start, input logic last);
		@(negedge clk);
		data_i  = data;
		valid_i = 1'b1;
		start_i = start;
		end_i   = last;
	endtask

	task automatic bus_idle();
		@(negedge clk);
		data_i  = '0;
		valid_i = 1'b0;
		start_i = 1'b0;
		end_i   = 1'b0;
	endtask

	// start byte then payload with end on the last byte
	task automatic send_frame(input msg_pkg::lane_t lane, input msg_pkg::byte_t payload[$]);
		int i;
		// upper bits of the select byte are ignored by the splitter
		send_byte({6'h2d, lane}, 1'b1, 1'b0);
		for (i = 0; i < payload.size(); i++) begin
			send_byte(payload[i], 1'b0, i == payload.size() - 1);
		end
	endtask

	task automatic get_burst(input string name, output logic ok, output burst_s b);
		int waited;
		waited = 0;
		ok = 1'b0;
		b = '0;
		while (bursts.size() == 0 && waited < BURST_WAIT) begin
			@(posedge clk);
			waited++;
		end
		if (bursts.size() > 0) begin
			b = bursts.pop_front();
			ok = 1'b1;
		end else begin
			$display("test %s: no output burst arrived within %0d cycles", name, BURST_WAIT);
			errors++;
		end
	endtask

	task automatic check_burst(input string name, input msg_pkg::lane_t lane,
			input msg_pkg::byte_t sum);
		logic ok;
		burst_s b;
		get_burst(name, ok, b);
		if (ok) begin
			check_lane(name, lane, b.lane);
			check_result(name, expect_digits(sum), b.chars);
		end
	endtask

	task automatic run_frame(input string name, input msg_pkg::lane_t lane,
			input msg_pkg::byte_t payload[$]);
		send_frame(lane, payload);
		bus_idle();
		check_burst(name, lane, payload_sum(payload));
	endtask

	// nothing more may come out
	task automatic expect_quiet(input string name, input int n);
		repeat (n) @(posedge clk);
		if (bursts.size() != 0) begin
			$display("test %s: %0d unexpected extra output bursts", name, bursts.size());
			errors += bursts.size();
			bursts.delete();
		end
	endtask

	task automatic finish_test(input string name, input int e0, input int c0);
		$display("test %s finished: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	task automatic single_frame();
		int e0;
		int c0;
		msg_pkg::byte_t p[$];
		e0 = errors;
		c0 = checks;
		// 0x12 + 0x05 + 0x21 = 56
		p = {8'h12, 8'h05, 8'h21};
		run_frame("single_frame", 2'd0, p);
		finish_test("single_frame", e0, c0);
	endtask

	task automatic boundary_sums();
		int e0;
		int c0;
		msg_pkg::byte_t p[$];
		e0 = errors;
		c0 = checks;
		// 256 wraps to 0
		p = {8'd128, 8'd128};
		run_frame("boundary_0", 2'd0, p);
		p = {8'd99};
		run_frame("boundary_99", 2'd1, p);
		p = {8'd50, 8'd50};
		run_frame("boundary_100", 2'd2, p);
		// 455 wraps to 199
		p = {8'd255, 8'd200};
		run_frame("boundary_199", 2'd3, p);
		p = {8'd200};
		run_frame("boundary_200", 2'd0, p);
		p = {8'd255};
		run_frame("boundary_255", 2'd1, p);
		// 300 wraps to 44
		p = {8'd200, 8'd100};
		run_frame("wrap_44", 2'd2, p);
		finish_test("boundary_sums", e0, c0);
	endtask

	task automatic all_lanes();
		int e0;
		int c0;
		int k;
		logic ok;
		burst_s b;
		logic [msg_pkg::NUM_LANES-1:0] seen;
		msg_pkg::byte_t exp_sum [msg_pkg::NUM_LANES];
		msg_pkg::byte_t p0[$];
		msg_pkg::byte_t p1[$];
		msg_pkg::byte_t p2[$];
		msg_pkg::byte_t p3[$];
		e0 = errors;
		c0 = checks;
		p0 = {8'd1, 8'd2};
		p1 = {8'd250, 8'd10, 8'd7};
		p2 = {8'd150};
		p3 = {8'd60, 8'd70, 8'd80, 8'd90};
		exp_sum[0] = payload_sum(p0);
		exp_sum[1] = payload_sum(p1);
		exp_sum[2] = payload_sum(p2);
		exp_sum[3] = payload_sum(p3);
		// no idle cycle between frames
		send_frame(2'd0, p0);
		send_frame(2'd1, p1);
		send_frame(2'd2, p2);
		send_frame(2'd3, p3);
		bus_idle();
		seen = '0;
		// bursts may come in any order and are matched by lane
		for (k = 0; k < msg_pkg::NUM_LANES; k++) begin
			get_burst("all_lanes", ok, b);
			if (ok) begin
				if (seen[b.lane]) begin
					$display("test all_lanes: lane %0d reported more than once", b.lane);
					errors++;
				end
				seen[b.lane] = 1'b1;
				check_result("all_lanes", expect_digits(exp_sum[b.lane]), b.chars);
			end
		end
		expect_quiet("all_lanes", 40);
		finish_test("all_lanes", e0, c0);
	endtask

	task automatic restart_frame();
		int e0;
		int c0;
		msg_pkg::byte_t p[$];
		e0 = errors;
		c0 = checks;
		// stray bytes with no frame open and one of them with end
		send_byte(8'h55, 1'b0, 1'b0);
		send_byte(8'h66, 1'b0, 1'b1);
		// partial frame on lane 1 that never ends
		send_byte(8'h01, 1'b1, 1'b0);
		send_byte(8'd10, 1'b0, 1'b0);
		send_byte(8'd20, 1'b0, 1'b0);
		// restart on lane 2 with 3 + 4 + 5 = 12
		send_byte(8'h02, 1'b1, 1'b0);
		send_byte(8'd3, 1'b0, 1'b0);
		send_byte(8'd4, 1'b0, 1'b0);
		send_byte(8'd5, 1'b0, 1'b1);
		send_byte(8'h77, 1'b0, 1'b0);
		bus_idle();
		check_burst("restart_frame", 2'd2, 8'd12);
		expect_quiet("restart_frame", 40);
		// lane 1 lost its partial sum and lane 2 ignored the stray byte
		p = {8'd9};
		run_frame("restart_lane1", 2'd1, p);
		run_frame("restart_lane2", 2'd2, p);
		finish_test("restart_frame", e0, c0);
	endtask

	task automatic random_frames();
		int e0;
		int c0;
		int f;
		int k;
		int len;
		logic [7:0] v;
		msg_pkg::lane_t lane;
		msg_pkg::byte_t p[$];
		e0 = errors;
		c0 = checks;
		// each burst is collected before the next frame ends on any lane
		for (f = 0; f < 20; f++) begin
			rand_bits(msg_pkg::LANE_W, v);
			lane = msg_pkg::lane_t'(v);
			rand_bits(3, v);
			len = int'(v) + 1;
			p = {};
			for (k = 0; k < len; k++) begin
				rand_bits(8, v);
				p.push_back(v);
			end
			run_frame("random_frames", lane, p);
		end
		finish_test("random_frames", e0, c0);
	endtask

	// run watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles", cycles);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		data_i = '0;
		valid_i = 1'b0;
		start_i = 1'b0;
		end_i = 1'b0;
		errors = 0;
		checks = 0;
		beat = 0;
		cap = '0;
		lfsr_state = SEED;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		single_frame();
		boundary_sums();
		all_lanes();
		restart_frame();
		random_frames();
		if (DUT.u_sva.fail_count != 0) begin
			$display("bound assertions failed %0d times", DUT.u_sva.fail_count);
			errors += DUT.u_sva.fail_count;
		end
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* msg_checksum.f */
hdl/msg_pkg.sv
hdl/frame_splitter.sv
hdl/checksum_lane.sv
hdl/digit_serializer.sv
hdl/msg_checksum_top.sv
tb/msg_checksum_sva.sv
tb/msg_checksum_tb.sv

/* Bender.yml */
package:
  name: msg_checksum

sources:
  # synthesizable design, package first
  - files:
      - hdl/msg_pkg.sv
      - hdl/frame_splitter.sv
      - hdl/checksum_lane.sv
      - hdl/digit_serializer.sv
      - hdl/msg_checksum_top.sv

  # simulation only
  - target: test
    files:
      - tb/msg_checksum_sva.sv
      - tb/msg_checksum_tb.sv
